//--- rtl/axi_lite_slave.sv
// AXI4-Lite slave port
module axi_lite_slave (
    input  logic                                i_aclk,
    input  logic                                i_aresetn,
    input  axil_pkg::axil_req_t                 i_axil,
    output axil_pkg::axil_rsp_t                 o_axil,
    output logic                                o_req,
    output axil_pkg::reg_req_t                  o_req_data,
    input  logic                                i_grant,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]    i_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_GRANT,
        ST_RESP
    } state_t;

    state_t wr_state;
    state_t rd_state;

    // Captured request payload
    logic [axil_pkg::AXIL_ADDR_W-1:0] wr_addr;
    logic [axil_pkg::AXIL_DATA_W-1:0] wr_data;
    logic [axil_pkg::AXIL_STRB_W-1:0] wr_strb;
    logic [axil_pkg::AXIL_ADDR_W-1:0] rd_addr;

    // Channel handshake and response registers
    logic                             awready;
    logic                             wready;
    logic                             bvalid;
    logic [1:0]                       bresp;
    logic                             arready;
    logic                             rvalid;
    logic [1:0]                       rresp;
    logic [axil_pkg::AXIL_DATA_W-1:0] rdata;

    logic aw_take;
    logic w_take;
    logic ar_take;
    logic aw_have;
    logic w_have;
    logic wr_ok;
    logic rd_ok;
    logic wr_pend;
    logic rd_pend;
    logic wr_grant;
    logic rd_grant;
    logic wr_done;
    logic rd_done;

    assign aw_take = i_axil.awvalid && awready;
    assign w_take  = i_axil.wvalid && wready;
    assign ar_take = i_axil.arvalid && arready;

    // While accepting, a low ready means that channel already transferred
    assign aw_have = aw_take || !awready;
    assign w_have  = w_take || !wready;

    // Only the low 256 bytes map onto the bank
    assign wr_ok = (wr_addr[axil_pkg::AXIL_ADDR_W-1:8] == '0);
    assign rd_ok = (rd_addr[axil_pkg::AXIL_ADDR_W-1:8] == '0);

    assign wr_pend = (wr_state == ST_GRANT) && wr_ok;
    assign rd_pend = (rd_state == ST_GRANT) && rd_ok;

    // Write wins when both sides of this port wait on the bank
    assign wr_grant = i_grant && wr_pend;
    assign rd_grant = i_grant && rd_pend && !wr_pend;

    // Out-of-range accesses finish without touching the bank
    assign wr_done = (wr_state == ST_GRANT) && (!wr_ok || wr_grant);
    assign rd_done = (rd_state == ST_GRANT) && (!rd_ok || rd_grant);

    assign o_req = wr_pend || rd_pend;

    always_comb begin
        if (wr_pend) begin
            o_req_data.wr    = 1'b1;
            o_req_data.idx   = wr_addr[axil_pkg::REG_IDX_W+1:2];
            o_req_data.wdata = wr_data;
            o_req_data.strb  = wr_strb;
        end else begin
            o_req_data.wr    = 1'b0;
            o_req_data.idx   = rd_addr[axil_pkg::REG_IDX_W+1:2];
            o_req_data.wdata = '0;
            o_req_data.strb  = '0;
        end
    end

    always_comb begin
        o_axil.awready = awready;
        o_axil.wready  = wready;
        o_axil.bvalid  = bvalid;
        o_axil.bresp   = bresp;
        o_axil.arready = arready;
        o_axil.rdata   = rdata;
        o_axil.rvalid  = rvalid;
        o_axil.rresp   = rresp;
    end

    // Write channel FSM
    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            wr_state <= ST_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            case (wr_state)
                ST_IDLE: begin
                    awready  <= 1'b1;
                    wready   <= 1'b1;
                    wr_state <= ST_ACCEPT;
                end
                ST_ACCEPT: begin
                    if (aw_take) begin
                        awready <= 1'b0;
                    end
                    if (w_take) begin
                        wready <= 1'b0;
                    end
                    if (aw_have && w_have) begin
                        wr_state <= ST_GRANT;
                    end
                end
                ST_GRANT: begin
                    if (wr_done) begin
                        bvalid   <= 1'b1;
                        wr_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // Next transaction opens on the edge that ends this one
                    if (i_axil.bready) begin
                        bvalid   <= 1'b0;
                        awready  <= 1'b1;
                        wready   <= 1'b1;
                        wr_state <= ST_ACCEPT;
                    end
                end
                default: wr_state <= ST_IDLE;
            endcase
        end
    end

    // Read channel FSM
    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            rd_state <= ST_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            case (rd_state)
                ST_IDLE: begin
                    arready  <= 1'b1;
                    rd_state <= ST_ACCEPT;
                end
                ST_ACCEPT: begin
                    if (ar_take) begin
                        arready  <= 1'b0;
                        rd_state <= ST_GRANT;
                    end
                end
                ST_GRANT: begin
                    if (rd_done) begin
                        rvalid   <= 1'b1;
                        rd_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (i_axil.rready) begin
                        rvalid   <= 1'b0;
                        arready  <= 1'b1;
                        rd_state <= ST_ACCEPT;
                    end
                end
                default: rd_state <= ST_IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge i_aclk) begin
        if (aw_take) begin
            wr_addr <= i_axil.awaddr;
        end
        if (w_take) begin
            wr_data <= i_axil.wdata;
            wr_strb <= i_axil.wstrb;
        end
        if (ar_take) begin
            rd_addr <= i_axil.araddr;
        end
        if (wr_done) begin
            bresp <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
        if (rd_done) begin
            rdata <= rd_ok ? i_rdata : '0;
            rresp <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    // Responses hold still until the master takes them
    a_bresp_stable: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        bvalid && !i_axil.bready |=> bvalid && $stable(bresp));

    a_rdata_stable: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        rvalid && !i_axil.rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- rtl/axil_dual_port_regs.sv
// Dual-port AXI4-Lite register block
module axil_dual_port_regs (
    input  logic                    i_aclk,
    input  logic                    i_aresetn,
    input  axil_pkg::axil_req_t     i_s0_axil,
    output axil_pkg::axil_rsp_t     o_s0_axil,
    input  axil_pkg::axil_req_t     i_s1_axil,
    output axil_pkg::axil_rsp_t     o_s1_axil
);

    // Slave to arbiter
    logic [axil_pkg::NUM_PORTS-1:0]   req;
    logic [axil_pkg::NUM_PORTS-1:0]   grant;
    axil_pkg::reg_req_t               req_data [axil_pkg::NUM_PORTS];

    // Arbiter to bank
    axil_pkg::reg_req_t               bank_req;
    logic                             bank_en;
    logic [axil_pkg::AXIL_DATA_W-1:0] bank_rdata;

    axi_lite_slave slave0 (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_axil     (i_s0_axil),
        .o_axil     (o_s0_axil),
        .o_req      (req[0]),
        .o_req_data (req_data[0]),
        .i_grant    (grant[0]),
        .i_rdata    (bank_rdata)
    );

    axi_lite_slave slave1 (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_axil     (i_s1_axil),
        .o_axil     (o_s1_axil),
        .o_req      (req[1]),
        .o_req_data (req_data[1]),
        .i_grant    (grant[1]),
        .i_rdata    (bank_rdata)
    );

    reg_arbiter arb0 (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_req      (req),
        .i_req_data (req_data),
        .o_grant    (grant),
        .o_bank_req (bank_req),
        .o_bank_en  (bank_en)
    );

    reg_bank bank0 (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_en       (bank_en),
        .i_req      (bank_req),
        .o_rdata    (bank_rdata)
    );

endmodule

//--- rtl/axil_pkg.sv
// AXI4-Lite register block definitions
package axil_pkg;

    // Bus widths
    localparam int AXIL_ADDR_W = 12;
    localparam int AXIL_DATA_W = 32;
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

    // Register bank geometry
    localparam int REG_COUNT = 64;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // Slave ports sharing the bank
    localparam int NUM_PORTS = 2;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Master side of one AXI4-Lite port
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // Slave side of one AXI4-Lite port
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic                   rvalid;
        logic [1:0]             rresp;
    } axil_rsp_t;

    // One register bank access
    typedef struct packed {
        logic                   wr;
        logic [REG_IDX_W-1:0]   idx;
        logic [AXIL_DATA_W-1:0] wdata;
        logic [AXIL_STRB_W-1:0] strb;
    } reg_req_t;

endpackage

//--- rtl/reg_arbiter.sv
// Round-robin register bank arbiter
module reg_arbiter (
    input  logic                                i_aclk,
    input  logic                                i_aresetn,
    input  logic [axil_pkg::NUM_PORTS-1:0]      i_req,
    input  axil_pkg::reg_req_t                  i_req_data [axil_pkg::NUM_PORTS],
    output logic [axil_pkg::NUM_PORTS-1:0]      o_grant,
    output axil_pkg::reg_req_t                  o_bank_req,
    output logic                                o_bank_en
);

    typedef logic [$clog2(axil_pkg::NUM_PORTS)-1:0] port_idx_t;

    // Port granted most recently
    port_idx_t last_q;
    port_idx_t sel;
    logic      found;

    // Search starts just past the last winner
    always_comb begin
        int unsigned cand;
        found   = 1'b0;
        sel     = '0;
        o_grant = '0;
        for (int unsigned k = 1; k <= axil_pkg::NUM_PORTS; k++) begin
            cand = (int'(last_q) + k) % axil_pkg::NUM_PORTS;
            if (!found && i_req[cand]) begin
                found         = 1'b1;
                sel           = port_idx_t'(cand);
                o_grant[cand] = 1'b1;
            end
        end
    end

    assign o_bank_en  = found;
    assign o_bank_req = i_req_data[sel];

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            // Port 0 wins the first contended cycle
            last_q <= port_idx_t'(axil_pkg::NUM_PORTS - 1);
        end else if (found) begin
            last_q <= sel;
        end
    end

    a_grant_onehot: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        $onehot0(o_grant));

    a_grant_to_requester: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        (o_grant & ~i_req) == '0);

endmodule

//--- rtl/reg_bank.sv
// Shared register bank
module reg_bank (
    input  logic                                i_aclk,
    input  logic                                i_aresetn,
    input  logic                                i_en,
    input  axil_pkg::reg_req_t                  i_req,
    output logic [axil_pkg::AXIL_DATA_W-1:0]    o_rdata
);

    logic [axil_pkg::AXIL_DATA_W-1:0] regs [axil_pkg::REG_COUNT];

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            for (int i = 0; i < axil_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_en && i_req.wr) begin
            // Byte lanes follow the write strobe
            for (int b = 0; b < axil_pkg::AXIL_STRB_W; b++) begin
                if (i_req.strb[b]) begin
                    regs[i_req.idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read of the requested index, also valid for writes
    assign o_rdata = regs[i_req.idx];

endmodule

//--- tb.f
rtl/axil_pkg.sv
rtl/axi_lite_slave.sv
rtl/reg_arbiter.sv
rtl/reg_bank.sv
rtl/axil_dual_port_regs.sv
testbench/tb_axil_dual_port_regs.sv

//--- testbench/tb_axil_dual_port_regs.sv
// Dual-port register block testbench
module tb_axil_dual_port_regs;

    localparam int CLK_PERIOD = 40;
    // Bus transactions over all tests, with some slack
    localparam int NUM_TRANS = 110;
    // Upper bound on one transaction under two-port contention
    localparam int MAX_TRANS_CYCLES = 12;

    logic                aclk;
    logic                aresetn;
    axil_pkg::axil_req_t mreq [2];
    axil_pkg::axil_rsp_t s0_rsp;
    axil_pkg::axil_rsp_t s1_rsp;

    // Expected contents of the bank
    logic [31:0] model [axil_pkg::REG_COUNT];
    logic [31:0] lcg_state;
    string       cur_test;
    int          value_errors;
    int          other_errors;

    axil_dual_port_regs dut0 (
        .i_aclk    (aclk),
        .i_aresetn (aresetn),
        .i_s0_axil (mreq[0]),
        .o_s0_axil (s0_rsp),
        .i_s1_axil (mreq[1]),
        .o_s1_axil (s1_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(NUM_TRANS * 100 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a transaction never finished",
                 NUM_TRANS * 100);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // New word after a write with byte enables
    function automatic logic [31:0] apply_strobe(input logic [31:0] old,
                                                 input logic [31:0] data,
                                                 input logic [3:0] strb);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    function automatic axil_pkg::axil_rsp_t port_rsp(input int port);
        return (port == 0) ? s0_rsp : s1_rsp;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        value_errors++;
    endtask

    // Order 1 sends the address first, order 2 the data first, 0 both at once
    task automatic axil_write(input int port, input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int order, input int hold,
                              output logic [1:0] resp);
        axil_pkg::axil_rsp_t r;
        logic aw_fire;
        logic w_fire;
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge aclk);
        mreq[port].awaddr  = addr;
        mreq[port].wdata   = data;
        mreq[port].wstrb   = strb;
        mreq[port].awvalid = (order != 2);
        mreq[port].wvalid  = (order != 1);
        while (!(aw_done && w_done)) begin
            r       = port_rsp(port);
            aw_fire = mreq[port].awvalid && r.awready;
            w_fire  = mreq[port].wvalid && r.wready;
            @(negedge aclk);
            if (aw_fire) begin
                mreq[port].awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_fire) begin
                mreq[port].wvalid = 1'b0;
                w_done = 1'b1;
            end
            if (aw_done && !w_done) mreq[port].wvalid = 1'b1;
            if (w_done && !aw_done) mreq[port].awvalid = 1'b1;
        end
        mreq[port].bready = (hold == 0);
        r = port_rsp(port);
        while (!r.bvalid) begin
            @(negedge aclk);
            r = port_rsp(port);
        end
        resp = r.bresp;
        // Stalled response must hold, and no new address may be taken
        for (int k = 0; k < hold; k++) begin
            @(negedge aclk);
            r = port_rsp(port);
            if (r.bresp !== resp) report_mismatch("bresp during stall", resp, r.bresp);
            if (r.bvalid !== 1'b1 || r.awready !== 1'b0) begin
                $display("%s: port %0d dropped bvalid or raised awready during stall",
                         cur_test, port);
                other_errors++;
            end
        end
        mreq[port].bready = 1'b1;
        @(negedge aclk);
        mreq[port].bready = 1'b0;
    endtask

    task automatic axil_read(input int port, input logic [11:0] addr,
                             output logic [31:0] data, output logic [1:0] resp);
        axil_pkg::axil_rsp_t r;
        @(negedge aclk);
        mreq[port].araddr  = addr;
        mreq[port].arvalid = 1'b1;
        r = port_rsp(port);
        while (!r.arready) begin
            @(negedge aclk);
            r = port_rsp(port);
        end
        @(negedge aclk);
        mreq[port].arvalid = 1'b0;
        mreq[port].rready  = 1'b1;
        r = port_rsp(port);
        while (!r.rvalid) begin
            @(negedge aclk);
            r = port_rsp(port);
        end
        data = r.rdata;
        resp = r.rresp;
        @(negedge aclk);
        mreq[port].rready = 1'b0;
    endtask

    task automatic write_checked(input int port, input logic [5:0] idx, input logic [31:0] data,
                                 input logic [3:0] strb, input int order);
        logic [1:0] resp;
        axil_write(port, {4'h0, idx, 2'b00}, data, strb, order, 0, resp);
        if (resp !== axil_pkg::RESP_OKAY) report_mismatch("bresp", axil_pkg::RESP_OKAY, resp);
        model[idx] = apply_strobe(model[idx], data, strb);
    endtask

    task automatic read_checked(input int port, input logic [5:0] idx);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(port, {4'h0, idx, 2'b00}, data, resp);
        if (resp !== axil_pkg::RESP_OKAY) report_mismatch("rresp", axil_pkg::RESP_OKAY, resp);
        if (data !== model[idx]) report_mismatch($sformatf("rdata reg %0d", idx), model[idx], data);
    endtask

    task automatic test_reset();
        axil_pkg::axil_rsp_t r;
        cur_test = "reset";
        for (int c = 0; c < 8; c++) begin
            @(negedge aclk);
            for (int p = 0; p < 2; p++) begin
                r = port_rsp(p);
                if ({r.awready, r.wready, r.arready, r.bvalid, r.rvalid} !== 5'b0) begin
                    $display("%s: port %0d has a ready or valid high in reset", cur_test, p);
                    other_errors++;
                end
            end
        end
        aresetn = 1'b1;
        repeat (2) @(negedge aclk);
        for (int p = 0; p < 2; p++) begin
            r = port_rsp(p);
            if ({r.awready, r.wready, r.arready, r.bvalid, r.rvalid} !== 5'b11100) begin
                $display("%s: port %0d readies not up two cycles after reset", cur_test, p);
                other_errors++;
            end
        end
    endtask

    task automatic test_cross_port();
        cur_test = "cross_port";
        write_checked(0, 6'd3, 32'hdeadbeef, 4'hf, 1);
        read_checked(1, 6'd3);
        write_checked(1, 6'd60, 32'h0badf00d, 4'hf, 2);
        read_checked(0, 6'd60);
        write_checked(0, 6'd17, 32'h12345678, 4'hf, 0);
        read_checked(1, 6'd17);
        write_checked(1, 6'd33, 32'hcafe0001, 4'hf, 1);
        read_checked(0, 6'd33);
    endtask

    task automatic test_strobes();
        cur_test = "strobes";
        write_checked(0, 6'd10, 32'h11223344, 4'hf, 0);
        write_checked(1, 6'd10, 32'haabbccdd, 4'b0101, 1);
        read_checked(0, 6'd10);
        write_checked(0, 6'd10, 32'h55667788, 4'b1000, 2);
        read_checked(1, 6'd10);
        write_checked(1, 6'd10, 32'hffffffff, 4'b0000, 0);
        read_checked(0, 6'd10);
    endtask

    task automatic test_out_of_range();
        logic [31:0] data;
        logic [1:0]  resp;
        cur_test = "out_of_range";
        // Low byte aliases register 1, which must stay untouched
        axil_write(0, 12'h104, 32'hffffffff, 4'hf, 0, 0, resp);
        if (resp !== axil_pkg::RESP_SLVERR) report_mismatch("bresp", axil_pkg::RESP_SLVERR, resp);
        read_checked(1, 6'd1);
        // Low byte aliases register 3, which holds a nonzero word
        axil_read(1, 12'hf0c, data, resp);
        if (resp !== axil_pkg::RESP_SLVERR) report_mismatch("rresp", axil_pkg::RESP_SLVERR, resp);
        if (data !== 32'h0) report_mismatch("rdata", 32'h0, data);
    endtask

    // Counts the transactions that finish within the latency bound
    task automatic run_traffic(input int port, input logic [5:0] base, output int done);
        logic [31:0] r;
        logic [5:0]  idx;
        time         t_start;
        done = 0;
        for (int n = 0; n < 40; n++) begin
            r       = next_rand();
            idx     = base + 6'(r[31:27]);
            t_start = $time;
            if (r[26]) write_checked(port, idx, next_rand(), r[25:22], int'(r[21:20]) % 3);
            else read_checked(port, idx);
            if ($time - t_start <= MAX_TRANS_CYCLES * CLK_PERIOD) done++;
        end
    endtask

    task automatic test_concurrent();
        int done0;
        int done1;
        cur_test = "concurrent";
        fork
            run_traffic(0, 6'd0, done0);
            run_traffic(1, 6'd32, done1);
        join
        if (done0 != 40) report_mismatch("port 0 transactions in time", 40, done0);
        if (done1 != 40) report_mismatch("port 1 transactions in time", 40, done1);
    endtask

    task automatic test_back_pressure();
        logic [1:0] resp;
        time        t_wr;
        time        t_rd;
        cur_test = "back_pressure";
        fork
            begin
                axil_write(0, {4'h0, 6'd5, 2'b00}, 32'h5a5aa5a5, 4'hf, 0, 10, resp);
                t_wr = $time;
            end
            begin
                repeat (4) @(negedge aclk);
                read_checked(1, 6'd40);
                t_rd = $time;
            end
        join
        if (resp !== axil_pkg::RESP_OKAY) report_mismatch("bresp", axil_pkg::RESP_OKAY, resp);
        model[5] = 32'h5a5aa5a5;
        if (t_rd >= t_wr) begin
            $display("%s: port 1 read did not finish while port 0 was stalled", cur_test);
            other_errors++;
        end
        read_checked(1, 6'd5);
    endtask

    initial begin
        aresetn      = 1'b0;
        mreq[0]      = '0;
        mreq[1]      = '0;
        lcg_state    = 32'hc90b;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < axil_pkg::REG_COUNT; i++) model[i] = '0;
        test_reset();
        test_cross_port();
        test_strobes();
        test_out_of_range();
        test_concurrent();
        test_back_pressure();
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
